/* logic/ahb_arbiter.sv */
`timescale 1ns/1ps

module ahb_arbiter (
    input  logic                      clk,
    input  logic                      rst_n,
    input  logic                      if_req,      // fetch side, held until granted
    input  logic [rv32_pkg::xlen-1:0] if_addr,
    output logic                      if_gnt,      // address phase accepted
    output logic                      if_rvalid,   // data phase done
    output logic [rv32_pkg::xlen-1:0] if_rdata,
    input  logic                      ls_req,      // data side, wins over fetch
    input  logic [rv32_pkg::xlen-1:0] ls_addr,
    input  logic                      ls_write,
    input  logic [rv32_pkg::xlen-1:0] ls_wdata,
    output logic                      ls_gnt,
    output logic                      ls_rvalid,
    output logic [rv32_pkg::xlen-1:0] ls_rdata,
    output logic [rv32_pkg::xlen-1:0] haddr,
    output logic [1:0]                htrans,
    output logic                      hwrite,
    output logic [rv32_pkg::xlen-1:0] hwdata,
    input  logic [rv32_pkg::xlen-1:0] hrdata,
    input  logic                      hready
);

    import rv32_pkg::*;

    logic dp_valid;                                 // a data phase is in progress
    logic dp_ls;                                    // owner of that data phase, 1 = load/store

    // address phase, data side has priority
    assign haddr  = ls_req ? ls_addr : if_addr;
    assign hwrite = ls_req & ls_write;              // fetches are always reads
    assign htrans = (ls_req | if_req) ? htrans_nonseq : htrans_idle;

    assign ls_gnt = ls_req & hready;
    assign if_gnt = if_req & ~ls_req & hready;      // fetch only when data side is quiet

    // response steering, one pulse when the data phase ends
    assign ls_rvalid = dp_valid & dp_ls & hready;
    assign if_rvalid = dp_valid & ~dp_ls & hready;
    assign ls_rdata  = hrdata;
    assign if_rdata  = hrdata;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            dp_valid <= 1'b0;
            dp_ls    <= 1'b0;
        end else if (hready) begin                  // phases advance only on hready
            dp_valid <= ls_req | if_req;
            dp_ls    <= ls_req;
        end
    end

    // write word follows its address phase by one cycle
    always_ff @(posedge clk) begin
        if (hready && ls_req) begin
            hwdata <= ls_wdata;                     // held while hready is low
        end
    end

endmodule

/* logic/execute_unit.sv */
`timescale 1ns/1ps

module execute_unit (
    input  logic                            clk,
    input  logic                            rst_n,
    input  logic                            instr_valid,
    input  rv32_pkg::instr_t                instr,
    input  logic [rv32_pkg::xlen-1:0]       instr_pc,
    output logic                            instr_take,
    output logic                            redirect,
    output logic [rv32_pkg::xlen-1:0]       redirect_pc,
    output logic [rv32_pkg::reg_addr_w-1:0] rs1_addr,
    output logic [rv32_pkg::reg_addr_w-1:0] rs2_addr,
    input  logic [rv32_pkg::xlen-1:0]       rs1_data,
    input  logic [rv32_pkg::xlen-1:0]       rs2_data,
    output logic                            rf_we,
    output logic [rv32_pkg::reg_addr_w-1:0] rf_waddr,
    output logic [rv32_pkg::xlen-1:0]       rf_wdata,
    output logic                            mem_start,   // one pulse per load or store
    output logic [rv32_pkg::xlen-1:0]       mem_addr,
    output logic                            mem_write,
    output logic [rv32_pkg::xlen-1:0]       mem_wdata,
    input  logic                            mem_done,
    input  logic [rv32_pkg::xlen-1:0]       mem_rdata
);

    import rv32_pkg::*;

    logic [6:0]      opcode;
    logic [2:0]      funct3;
    logic            is_reg, is_imm, is_load, is_store, is_branch, is_mem;
    logic            is_sub;
    logic            alu_ok;                       // funct3 is one of the kept alu ops
    logic            busy;                         // memory op handed off, not yet done
    logic            br_taken;
    logic [xlen-1:0] imm_i, imm_s, imm_b;
    logic [xlen-1:0] op_b;
    logic [xlen-1:0] alu_result;

    // opcode and funct3 sit at the same bits in every view
    assign opcode = instr.r.opcode;
    assign funct3 = instr.r.funct3;

    assign is_reg    = (opcode == op_reg);
    assign is_imm    = (opcode == op_imm);
    assign is_load   = (opcode == op_load)  && (funct3 == f3_word); // word access only
    assign is_store  = (opcode == op_store) && (funct3 == f3_word);
    assign is_branch = (opcode == op_branch);
    assign is_mem    = is_load | is_store;
    assign is_sub    = is_reg & (instr.r.funct7 == f7_sub);
    assign alu_ok    = (funct3 == f3_add) | (funct3 == f3_xor) |
                       (funct3 == f3_or)  | (funct3 == f3_and);

    // immediates, sign extended from each format
    assign imm_i = {{20{instr.i.imm[11]}}, instr.i.imm};
    assign imm_s = {{20{instr.s.imm_hi[6]}}, instr.s.imm_hi, instr.s.imm_lo};
    assign imm_b = {{19{instr.b.imm_12}}, instr.b.imm_12, instr.b.imm_11,
                    instr.b.imm_10_5, instr.b.imm_4_1, 1'b0};

    assign rs1_addr = instr.r.rs1;
    assign rs2_addr = instr.r.rs2;

    assign op_b = is_reg ? rs2_data : imm_i;

    always_comb begin
        case (funct3)
            f3_add:  alu_result = is_sub ? (rs1_data - op_b) : (rs1_data + op_b);
            f3_xor:  alu_result = rs1_data ^ op_b;
            f3_or:   alu_result = rs1_data | op_b;
            f3_and:  alu_result = rs1_data & op_b;
            default: alu_result = '0;              // not written back
        endcase
    end

    // branch compare, target relative to the branch itself
    always_comb begin
        case (funct3)
            f3_beq:  br_taken = is_branch & (rs1_data == rs2_data);
            f3_bne:  br_taken = is_branch & (rs1_data != rs2_data);
            default: br_taken = 1'b0;
        endcase
    end

    assign redirect    = instr_valid & br_taken;  // retires in this cycle too
    assign redirect_pc = instr_pc + imm_b;

    // alu and branch retire at once, memory ops wait for done
    assign instr_take = instr_valid & (~is_mem | mem_done);

    assign mem_start = instr_valid & is_mem & ~busy;
    assign mem_addr  = rs1_data + (is_store ? imm_s : imm_i);
    assign mem_write = is_store;
    assign mem_wdata = rs2_data;

    // write back in the execute cycle, or when the load word arrives
    assign rf_we    = instr_valid & (((is_reg | is_imm) & alu_ok) | (is_load & mem_done));
    assign rf_waddr = instr.r.rd;
    assign rf_wdata = is_load ? mem_rdata : alu_result;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            busy <= 1'b0;
        end else if (mem_done) begin
            busy <= 1'b0;
        end else if (mem_start) begin
            busy <= 1'b1;                          // blocks a second start
        end
    end

endmodule

/* logic/fetch_unit.sv */
`timescale 1ns/1ps

module fetch_unit (
    input  logic                      clk,
    input  logic                      rst_n,
    output logic                      if_req,
    output logic [rv32_pkg::xlen-1:0] if_addr,
    input  logic                      if_gnt,
    input  logic                      if_rvalid,
    input  logic [rv32_pkg::xlen-1:0] if_rdata,
    output logic                      instr_valid,  // buffer holds a word
    output rv32_pkg::instr_t          instr,
    output logic [rv32_pkg::xlen-1:0] instr_pc,
    input  logic                      instr_take,   // execute retires the word
    input  logic                      redirect,     // taken branch
    input  logic [rv32_pkg::xlen-1:0] redirect_pc
);

    import rv32_pkg::*;

    logic            pending;                      // address accepted, waiting for data
    logic            discard;                      // outstanding fetch is on the wrong path
    logic            issue;                        // raise a new request this cycle
    logic [xlen-1:0] next_pc;                      // address of the following request
    logic [xlen-1:0] pc_sel;

    assign pc_sel = redirect ? redirect_pc : next_pc;
    // prefetch on every response, or start from idle after reset
    assign issue  = if_rvalid | (~if_req & ~pending & ~instr_valid);

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            if_req      <= 1'b0;
            if_addr     <= reset_pc;
            next_pc     <= reset_pc;
            pending     <= 1'b0;
            discard     <= 1'b0;
            instr_valid <= 1'b0;
        end else begin
            if (if_gnt) begin
                if_req  <= 1'b0;
                pending <= 1'b1;
            end
            if (instr_take) instr_valid <= 1'b0;
            if (if_rvalid) begin
                pending <= 1'b0;
                discard <= 1'b0;                   // the stale word is gone now
                if (!discard && !redirect) instr_valid <= 1'b1;
            end
            if (issue) begin
                if_req  <= 1'b1;
                if_addr <= pc_sel;                 // held until granted
                next_pc <= pc_sel + 32'd4;
            end else if (redirect) begin
                next_pc <= redirect_pc;
            end
            // an older fetch is still out, drop its word when it lands
            if (redirect && (if_req || (pending && !if_rvalid))) discard <= 1'b1;
        end
    end

    // word and its pc, if_addr still names the returning fetch
    always_ff @(posedge clk) begin
        if (if_rvalid && !discard) begin
            instr    <= if_rdata;
            instr_pc <= if_addr;
        end
    end

endmodule

/* logic/load_store_unit.sv */
`timescale 1ns/1ps

module load_store_unit (
    input  logic                      clk,
    input  logic                      rst_n,
    input  logic                      mem_start,
    input  logic [rv32_pkg::xlen-1:0] mem_addr,
    input  logic                      mem_write,
    input  logic [rv32_pkg::xlen-1:0] mem_wdata,
    output logic                      mem_done,
    output logic [rv32_pkg::xlen-1:0] mem_rdata,
    output logic                      ls_req,
    output logic [rv32_pkg::xlen-1:0] ls_addr,
    output logic                      ls_write,
    output logic [rv32_pkg::xlen-1:0] ls_wdata,
    input  logic                      ls_gnt,
    input  logic                      ls_rvalid,
    input  logic [rv32_pkg::xlen-1:0] ls_rdata
);

    import rv32_pkg::*;

    logic            req_q;                        // request still waiting for grant
    logic            wait_q;                       // granted, data phase outstanding
    logic [xlen-1:0] addr_q, wdata_q;
    logic            write_q;

    // start requests in its own cycle so it beats a fetch in the arbiter
    assign ls_req   = mem_start | req_q;
    assign ls_addr  = req_q ? addr_q  : mem_addr;
    assign ls_write = req_q ? write_q : mem_write;
    assign ls_wdata = req_q ? wdata_q : mem_wdata;

    assign mem_done  = wait_q & ls_rvalid;
    assign mem_rdata = ls_rdata;                   // only used for lw

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            req_q  <= 1'b0;
            wait_q <= 1'b0;
        end else begin
            if (ls_rvalid) wait_q <= 1'b0;
            if (ls_gnt) begin
                req_q  <= 1'b0;
                wait_q <= 1'b1;
            end else if (mem_start) begin
                req_q  <= 1'b1;                    // bus busy, keep asking
            end
        end
    end

    always_ff @(posedge clk) begin
        if (mem_start) begin
            addr_q  <= mem_addr;
            write_q <= mem_write;
            wdata_q <= mem_wdata;
        end
    end

endmodule

/* logic/reg_file.sv */
`timescale 1ns/1ps

module reg_file (
    input  logic                            clk,
    input  logic [rv32_pkg::reg_addr_w-1:0] raddr_a,
    input  logic [rv32_pkg::reg_addr_w-1:0] raddr_b,
    output logic [rv32_pkg::xlen-1:0]       rdata_a,
    output logic [rv32_pkg::xlen-1:0]       rdata_b,
    input  logic                            we,
    input  logic [rv32_pkg::reg_addr_w-1:0] waddr,
    input  logic [rv32_pkg::xlen-1:0]       wdata
);

    import rv32_pkg::*;

    logic [xlen-1:0] regs [1:31];                  // x0 has no storage

    // combinational reads, x0 reads as zero
    assign rdata_a = (raddr_a == '0) ? '0 : regs[raddr_a];
    assign rdata_b = (raddr_b == '0) ? '0 : regs[raddr_b];

    always_ff @(posedge clk) begin
        if (we && waddr != '0) begin               // writes to x0 vanish
            regs[waddr] <= wdata;
        end
    end

endmodule

/* logic/rv32_core_ahb.sv */
`timescale 1ns/1ps

module rv32_core_ahb (
    input  logic                      clk,
    input  logic                      rst_n,
    output logic [rv32_pkg::xlen-1:0] haddr,
    output logic [1:0]                htrans,
    output logic                      hwrite,
    output logic [rv32_pkg::xlen-1:0] hwdata,
    input  logic [rv32_pkg::xlen-1:0] hrdata,
    input  logic                      hready
);

    import rv32_pkg::*;

    logic                  if_req, if_gnt, if_rvalid;
    logic [xlen-1:0]       if_addr, if_rdata;
    logic                  ls_req, ls_write, ls_gnt, ls_rvalid;
    logic [xlen-1:0]       ls_addr, ls_wdata, ls_rdata;
    logic                  instr_valid, instr_take, redirect;
    instr_t                instr;
    logic [xlen-1:0]       instr_pc, redirect_pc;
    logic [reg_addr_w-1:0] rs1_addr, rs2_addr, rf_waddr;
    logic [xlen-1:0]       rs1_data, rs2_data, rf_wdata;
    logic                  rf_we;
    logic                  mem_start, mem_write, mem_done;
    logic [xlen-1:0]       mem_addr, mem_wdata, mem_rdata;

    ahb_arbiter u_arbiter (
        .clk, .rst_n,
        .if_req, .if_addr, .if_gnt, .if_rvalid, .if_rdata,
        .ls_req, .ls_addr, .ls_write, .ls_wdata, .ls_gnt, .ls_rvalid, .ls_rdata,
        .haddr, .htrans, .hwrite, .hwdata, .hrdata, .hready
    );

    fetch_unit u_fetch (
        .clk, .rst_n,
        .if_req, .if_addr, .if_gnt, .if_rvalid, .if_rdata,
        .instr_valid, .instr, .instr_pc, .instr_take, .redirect, .redirect_pc
    );

    reg_file u_regs (
        .clk,
        .raddr_a (rs1_addr),
        .raddr_b (rs2_addr),
        .rdata_a (rs1_data),
        .rdata_b (rs2_data),
        .we      (rf_we),
        .waddr   (rf_waddr),
        .wdata   (rf_wdata)
    );

    execute_unit u_execute (
        .clk, .rst_n,
        .instr_valid, .instr, .instr_pc, .instr_take, .redirect, .redirect_pc,
        .rs1_addr, .rs2_addr, .rs1_data, .rs2_data,
        .rf_we, .rf_waddr, .rf_wdata,
        .mem_start, .mem_addr, .mem_write, .mem_wdata, .mem_done, .mem_rdata
    );

    load_store_unit u_lsu (
        .clk, .rst_n,
        .mem_start, .mem_addr, .mem_write, .mem_wdata, .mem_done, .mem_rdata,
        .ls_req, .ls_addr, .ls_write, .ls_wdata, .ls_gnt, .ls_rvalid, .ls_rdata
    );

endmodule

/* logic/rv32_pkg.sv */
package rv32_pkg;

    localparam int xlen       = 32;                  // data and address width
    localparam int reg_addr_w = 5;                   // x0..x31

    localparam logic [1:0] htrans_idle   = 2'b00;    // no transfer
    localparam logic [1:0] htrans_nonseq = 2'b10;    // single transfer, never bursts here

    localparam logic [xlen-1:0] reset_pc = 32'h0000_0000; // first fetch address

    // opcodes of the kept RV32I subset
    localparam logic [6:0] op_reg    = 7'b0110011;   // add sub and or xor
    localparam logic [6:0] op_imm    = 7'b0010011;   // addi
    localparam logic [6:0] op_load   = 7'b0000011;   // lw
    localparam logic [6:0] op_store  = 7'b0100011;   // sw
    localparam logic [6:0] op_branch = 7'b1100011;   // beq bne

    localparam logic [2:0] f3_add  = 3'b000;         // add, sub, addi
    localparam logic [2:0] f3_xor  = 3'b100;
    localparam logic [2:0] f3_or   = 3'b110;
    localparam logic [2:0] f3_and  = 3'b111;
    localparam logic [2:0] f3_beq  = 3'b000;
    localparam logic [2:0] f3_bne  = 3'b001;
    localparam logic [2:0] f3_word = 3'b010;         // lw / sw width

    localparam logic [6:0] f7_sub = 7'b0100000;      // funct7 of sub

    typedef struct packed {
        logic [6:0] funct7;
        logic [4:0] rs2;
        logic [4:0] rs1;
        logic [2:0] funct3;
        logic [4:0] rd;
        logic [6:0] opcode;
    } r_fmt_t;

    typedef struct packed {
        logic [11:0] imm;                            // sign bit is imm[11]
        logic [4:0]  rs1;
        logic [2:0]  funct3;
        logic [4:0]  rd;
        logic [6:0]  opcode;
    } i_fmt_t;

    typedef struct packed {
        logic [6:0] imm_hi;                          // imm[11:5]
        logic [4:0] rs2;
        logic [4:0] rs1;
        logic [2:0] funct3;
        logic [4:0] imm_lo;                          // imm[4:0]
        logic [6:0] opcode;
    } s_fmt_t;

    typedef struct packed {
        logic       imm_12;                          // offset sign
        logic [5:0] imm_10_5;
        logic [4:0] rs2;
        logic [4:0] rs1;
        logic [2:0] funct3;
        logic [3:0] imm_4_1;
        logic       imm_11;
        logic [6:0] opcode;
    } b_fmt_t;

    // one fetched word, viewed per opcode
    typedef union packed {
        r_fmt_t r;
        i_fmt_t i;
        s_fmt_t s;
        b_fmt_t b;
    } instr_t;

endpackage

/* run.sh */
#!/bin/sh
verilator --binary -j 0 --top-module tb_top -f src.f -o tb_sim &&
    ./obj_dir/tb_sim | tee /dev/stderr | grep -q "^test passed$" ||
    { echo "simulation did not pass" >&2; exit 1; }

/* src.f */
logic/rv32_pkg.sv
logic/ahb_arbiter.sv
logic/fetch_unit.sv
logic/reg_file.sv
logic/execute_unit.sv
logic/load_store_unit.sv
logic/rv32_core_ahb.sv
verif/ahb_checker.sv
verif/tb_top.sv

/* verif/ahb_checker.sv */
`timescale 1ns/1ps

module ahb_checker (
    input  logic                      clk,
    input  logic                      rst_n,
    input  logic [rv32_pkg::xlen-1:0] haddr,
    input  logic [1:0]                htrans,
    input  logic                      hwrite,
    input  logic [rv32_pkg::xlen-1:0] hwdata,
    input  logic                      hready,
    input  int                        exp_n,        // stores expected in this case
    input  logic [rv32_pkg::xlen-1:0] exp_addr0,
    input  logic [rv32_pkg::xlen-1:0] exp_data0,
    input  logic [rv32_pkg::xlen-1:0] exp_addr1,
    input  logic [rv32_pkg::xlen-1:0] exp_data1,
    output int                        store_seen,   // stores of this case, cleared by reset
    output int                        store_total,
    output int                        error_count
);

    import rv32_pkg::*;

    logic            wr_dp;                        // a write data phase is running
    logic [xlen-1:0] wr_addr;                      // its address from the address phase
    logic [xlen-1:0] want_addr;
    logic [xlen-1:0] want_data;
    int              errors = 0;
    int              total  = 0;                   // survives the per-case reset

    assign want_addr   = (store_seen == 0) ? exp_addr0 : exp_addr1;
    assign want_data   = (store_seen == 0) ? exp_data0 : exp_data1;
    assign error_count = errors;
    assign store_total = total;

    always @(posedge clk) begin
        int bad;
        bad = 0;
        if (!rst_n) begin
            wr_dp      <= 1'b0;
            store_seen <= 0;
        end else if (hready) begin                 // data phase ends, next address phase taken
            if (wr_dp) begin
                if (store_seen >= exp_n) begin
                    $display("unexpected store at %0t to address %h with data %h",
                             $time, wr_addr, hwdata);
                    bad = bad + 1;
                end else begin
                    if (wr_addr !== want_addr) begin
                        $display("error at %0t: haddr is %h, expected %h",
                                 $time, wr_addr, want_addr);
                        bad = bad + 1;
                    end
                    if (hwdata !== want_data) begin
                        $display("error at %0t: hwdata is %h, expected %h",
                                 $time, hwdata, want_data);
                        bad = bad + 1;
                    end
                end
                store_seen <= store_seen + 1;
                total      <= total + 1;
            end
            wr_dp   <= (htrans == htrans_nonseq) && hwrite;   // fetches never set this
            wr_addr <= haddr;
            errors  <= errors + bad;
        end
    end

endmodule

/* verif/tb_top.sv */
`timescale 1ns/1ps

module tb_top;

    import rv32_pkg::*;

    localparam int n_cases   = 13;
    localparam int mem_words = 256;                // program from 0, data around 0x200
    localparam int wait_max  = 3000;               // cycles allowed for the stores of one case

    typedef enum logic [3:0] {k_add, k_sub, k_and, k_or, k_xor, k_addi, k_lw,
                              k_beq, k_bne, k_two} case_op_t;

    typedef struct packed {
        case_op_t    op;
        logic [11:0] a;
        logic [11:0] b;
        logic [31:0] word;                         // lw source at 0x204
    } case_row_t;

    case_row_t cases [n_cases] = '{
        '{k_add,  12'h123, 12'h456, 32'h0000_0000},
        '{k_sub,  12'h005, 12'h7ff, 32'h0000_0000},   // negative difference
        '{k_and,  12'hf0f, 12'h0ff, 32'h0000_0000},
        '{k_or,   12'h800, 12'h00f, 32'h0000_0000},
        '{k_xor,  12'haaa, 12'h555, 32'h0000_0000},
        '{k_addi, 12'h100, 12'hf38, 32'h0000_0000},   // imm is -200
        '{k_lw,   12'h7ff, 12'h000, 32'h8000_0001},
        '{k_lw,   12'h801, 12'h000, 32'h1234_5678},
        '{k_beq,  12'h042, 12'h042, 32'h0000_0000},
        '{k_beq,  12'h042, 12'h043, 32'h0000_0000},
        '{k_bne,  12'h042, 12'h043, 32'h0000_0000},
        '{k_bne,  12'hfff, 12'hfff, 32'h0000_0000},
        '{k_two,  12'h321, 12'h9ab, 32'h0000_0000}
    };

    logic            clk    = 1'b0;
    logic            rst_n  = 1'b0;
    logic            hready = 1'b1;
    logic [xlen-1:0] hrdata = '0;
    logic [xlen-1:0] haddr, hwdata;
    logic [1:0]      htrans;
    logic            hwrite;
    logic [31:0]     lfsr_state = 32'h6981_e6bd;
    logic [xlen-1:0] mem   [mem_words];            // slave memory
    logic [xlen-1:0] image [mem_words];            // copied into mem during reset
    logic            dp_valid, dp_write;
    logic [xlen-1:0] dp_addr;
    int              exp_n = 0;
    logic [xlen-1:0] exp_addr0 = '0, exp_data0 = '0, exp_addr1 = '0, exp_data1 = '0;
    int              store_seen, store_total, error_count;
    int              timeouts = 0;
    int              emit_pos = 0;

    always #5 clk = ~clk;

    rv32_core_ahb uut (
        .clk, .rst_n, .haddr, .htrans, .hwrite, .hwdata, .hrdata, .hready
    );

    ahb_checker u_checker (
        .clk, .rst_n, .haddr, .htrans, .hwrite, .hwdata, .hready,
        .exp_n, .exp_addr0, .exp_data0, .exp_addr1, .exp_data1,
        .store_seen, .store_total, .error_count
    );

    // taps 32 22 2 1
    function automatic logic [31:0] lfsr_step(input logic [31:0] s);
        return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
    endfunction

    function automatic logic [31:0] sext12(input logic [11:0] v);
        return {{20{v[11]}}, v};
    endfunction

    function automatic logic [31:0] rtype_word(input logic [6:0] f7, input logic [4:0] rs2,
            input logic [4:0] rs1, input logic [2:0] f3, input logic [4:0] rd);
        return {f7, rs2, rs1, f3, rd, op_reg};
    endfunction

    function automatic logic [31:0] itype_word(input logic [6:0] op, input logic [11:0] imm,
            input logic [4:0] rs1, input logic [2:0] f3, input logic [4:0] rd);
        return {imm, rs1, f3, rd, op};
    endfunction

    // sw rs2, imm(rs1)
    function automatic logic [31:0] stype_word(input logic [11:0] imm, input logic [4:0] rs2,
            input logic [4:0] rs1);
        return {imm[11:5], rs2, rs1, f3_word, imm[4:0], op_store};
    endfunction

    function automatic logic [31:0] btype_word(input logic [2:0] f3, input logic [4:0] rs1,
            input logic [4:0] rs2, input logic [12:0] off);
        return {off[12], off[10:5], rs2, rs1, f3, off[4:1], off[11], op_branch};
    endfunction

    // pipelined slave, write lands when its data phase ends
    always @(posedge clk) begin
        if (!rst_n) begin
            mem      <= image;
            dp_valid <= 1'b0;
            dp_write <= 1'b0;
        end else if (hready) begin
            if (dp_valid && dp_write) mem[dp_addr[9:2]] <= hwdata;
            dp_valid <= (htrans == htrans_nonseq);
            dp_addr  <= haddr;
            dp_write <= hwrite;
        end
    end

    // one lfsr bit per cycle decides the wait state
    always @(negedge clk) begin
        logic [31:0] nxt;
        nxt = lfsr_step(lfsr_state);
        lfsr_state <= nxt;
        hready     <= ~nxt[0];
        hrdata     <= (dp_valid && !dp_write) ? mem[dp_addr[9:2]] : '0;
    end

    task automatic emit(input logic [31:0] w);
        image[emit_pos[7:0]] = w;
        emit_pos++;
    endtask

    // x1 = a, x2 = b, then the op under test, expected stores by the isa rules
    task automatic build_case(input case_row_t row);
        logic [31:0] sa, sb, halt;
        logic        taken;
        sa   = sext12(row.a);
        sb   = sext12(row.b);
        halt = btype_word(f3_beq, 5'd0, 5'd0, 13'd0);   // spins on itself
        for (int i = 0; i < mem_words; i++) image[i[7:0]] = {i[29:0], 2'b00} ^ 32'hdead_beef;
        image[8'h81] = row.word;                        // word address 0x204
        emit_pos  = 0;
        exp_n     = 1;
        exp_addr0 = 32'h0000_0200;
        exp_addr1 = '0;
        exp_data1 = '0;
        emit(itype_word(op_imm, row.a, 5'd0, f3_add, 5'd1));
        emit(itype_word(op_imm, row.b, 5'd0, f3_add, 5'd2));
        case (row.op)
            k_add:  exp_data0 = sa + sb;
            k_sub:  exp_data0 = sa - sb;
            k_and:  exp_data0 = sa & sb;
            k_or:   exp_data0 = sa | sb;
            k_xor:  exp_data0 = sa ^ sb;
            k_addi: exp_data0 = sa + sb;
            k_lw:   exp_data0 = row.word + sa;
            default: exp_data0 = '0;
        endcase
        case (row.op)
            k_add:  emit(rtype_word(7'd0, 5'd2, 5'd1, f3_add, 5'd3));
            k_sub:  emit(rtype_word(f7_sub, 5'd2, 5'd1, f3_add, 5'd3));
            k_and:  emit(rtype_word(7'd0, 5'd2, 5'd1, f3_and, 5'd3));
            k_or:   emit(rtype_word(7'd0, 5'd2, 5'd1, f3_or, 5'd3));
            k_xor:  emit(rtype_word(7'd0, 5'd2, 5'd1, f3_xor, 5'd3));
            k_addi: emit(itype_word(op_imm, row.b, 5'd1, f3_add, 5'd3));
            k_lw: begin
                emit(itype_word(op_load, 12'h204, 5'd0, f3_word, 5'd4));
                emit(rtype_word(7'd0, 5'd1, 5'd4, f3_add, 5'd3));   // uses x4 right away
            end
            k_beq, k_bne: begin
                emit(btype_word(row.op == k_beq ? f3_beq : f3_bne, 5'd1, 5'd2, 13'd12));
                emit(stype_word(12'h200, 5'd1, 5'd0));             // not taken marker
                emit(halt);
                emit(stype_word(12'h20c, 5'd2, 5'd0));             // taken marker
                taken     = (row.op == k_beq) ? (sa == sb) : (sa != sb);
                exp_addr0 = taken ? 32'h0000_020c : 32'h0000_0200;
                exp_data0 = taken ? sb : sa;
            end
            default: begin
                emit(rtype_word(7'd0, 5'd2, 5'd1, f3_add, 5'd3));
                emit(stype_word(12'h210, 5'd1, 5'd0));
                exp_n     = 2;
                exp_addr0 = 32'h0000_0210;
                exp_data0 = sa;
                exp_addr1 = 32'h0000_0214;
                exp_data1 = sa + sb;
                emit(stype_word(12'h214, 5'd3, 5'd0));
            end
        endcase
        if (row.op <= k_lw) emit(stype_word(12'h200, 5'd3, 5'd0));
        emit(halt);
    endtask

    initial begin
        int cycles;
        for (int c = 0; c < n_cases; c++) begin
            @(negedge clk);
            rst_n = 1'b0;
            build_case(cases[c[3:0]]);
            repeat (5) @(negedge clk);
            rst_n  = 1'b1;
            cycles = 0;
            while (store_seen < exp_n && cycles < wait_max) begin
                @(negedge clk);
                cycles++;
            end
            if (store_seen < exp_n) begin
                $display("case %0d hung: %0d of %0d stores seen after %0d cycles",
                         c, store_seen, exp_n, cycles);
                timeouts++;
            end
            repeat (20) @(negedge clk);            // a stray extra store would show here
        end
        $display("cases %0d, stores checked %0d, errors %0d, timeouts %0d",
                 n_cases, store_total, error_count, timeouts);
        if (error_count == 0 && timeouts == 0) begin
            $display("test passed");
        end else begin
            $display("test failed");
        end
        $finish;
    end

endmodule
